// ==== tb.f ====
src/memCtrlPkg.sv
src/memBusPkg.sv
src/memSequencer.sv
src/wordAssembler.sv
src/byteRam.sv
src/memSubsystem.sv
sim/tbMemSubsystem.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  # packages first, the bus package uses the control package
  - files:
      - src/memCtrlPkg.sv
      - src/memBusPkg.sv

  # RTL, leaf modules before the top level
  - files:
      - src/memSequencer.sv
      - src/wordAssembler.sv
      - src/byteRam.sv
      - src/memSubsystem.sv

  # testbench, top module tbMemSubsystem
  - target: simulation
    files:
      - sim/tbMemSubsystem.sv

// ==== sim/tbMemSubsystem.sv ====
`timescale 1ns/1ps

module tbMemSubsystem;

    localparam int RamAddrWidth = 12;
    localparam int RamDepth     = 2 ** RamAddrWidth;
    localparam int ClkPeriod    = 40;
    localparam int ResetCycles  = 5;
    localparam int IdleCycles   = 10;
    localparam int Seed         = 62801;

    // stall cycles allowed inside one transfer
    localparam int MaxStall     = 8;
    localparam int StallRounds  = 10;
    localparam int MaxTransfers = 64;
    // longest transfer is a word read, five cycles plus its stalls
    localparam int WaitLimit      = 5 + MaxStall + 1;
    localparam int TransferCycles = WaitLimit + 2;
    localparam int TotalCycles    = 2 * ResetCycles + IdleCycles + MaxTransfers * TransferCycles;

    logic                  clk;
    logic                  rst;
    logic                  rdy;
    logic                  ioBufferFull;
    memBusPkg::fetchReq_s  fetchIn;
    memBusPkg::dataReq_s   dataIn;
    memBusPkg::fetchResp_s fetchOut;
    memBusPkg::dataResp_s  dataOut;

    // reference copy of the RAM, written by the testbench stores
    logic [7:0] refMem [RamDepth];

    bit stallOn;
    int stallBudget;
    int stallCount;

    memSubsystem #(
        .RamAddrWidth (RamAddrWidth)
    ) i_memSubsystem (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (rdy),
        .i_ioBufferFull (ioBufferFull),
        .i_fetch        (fetchIn),
        .i_data         (dataIn),
        .o_fetch        (fetchOut),
        .o_data         (dataOut)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(2 * TotalCycles * ClkPeriod);
        failRun("watchdog expired before the tests finished");
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkFetch(input memBusPkg::fetchResp_s got,
                              input memBusPkg::fetchResp_s exp, input string what);
        if (got.done !== exp.done) begin
            failRun($sformatf("[ERROR] %s o_fetch.done got %h expected %h",
                              what, got.done, exp.done));
        end
        if (got.inst !== exp.inst) begin
            failRun($sformatf("[ERROR] %s o_fetch.inst got %h expected %h",
                              what, got.inst, exp.inst));
        end
    endtask

    task automatic checkData(input memBusPkg::dataResp_s got,
                             input memBusPkg::dataResp_s exp, input string what);
        if (got.done !== exp.done) begin
            failRun($sformatf("[ERROR] %s o_data.done got %h expected %h",
                              what, got.done, exp.done));
        end
        if (got.rdata !== exp.rdata) begin
            failRun($sformatf("[ERROR] %s o_data.rdata got %h expected %h",
                              what, got.rdata, exp.rdata));
        end
    endtask

    // negative expected latency means stalls make it unknown
    task automatic checkLatency(input string what, input int got, input int exp);
        if (exp >= 0 && got != exp) begin
            failRun($sformatf("%s done came %0d cycles after acceptance, expected %0d",
                              what, got, exp));
        end
    endtask

    function automatic void modelWrite(input logic [31:0] addr,
                                       input memCtrlPkg::accessLen_e count,
                                       input logic [31:0] wdata);
        memBusPkg::wordLanes_u w;
        logic [31:0]           a;
        w.word = wdata;
        for (int i = 0; i < int'(count); i++) begin
            a = addr + 32'(i);
            refMem[a[RamAddrWidth-1:0]] = w.lanes[i];
        end
    endfunction

    // little-endian, zero above the byte count
    function automatic logic [31:0] modelRead(input logic [31:0] addr, input int count);
        memBusPkg::wordLanes_u w;
        logic [31:0]           a;
        w.word = '0;
        for (int i = 0; i < count; i++) begin
            a = addr + 32'(i);
            w.lanes[i] = refMem[a[RamAddrWidth-1:0]];
        end
        return w.word;
    endfunction

    function automatic memCtrlPkg::accessLen_e pickLen();
        case ($urandom % 3)
            0: return memCtrlPkg::lenByte;
            1: return memCtrlPkg::lenHalf;
            default: return memCtrlPkg::lenWord;
        endcase
    endfunction

    task automatic applyStall();
        int pick;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        if (stallOn && stallBudget > 0) begin
            pick = $urandom % 4;
            if (pick == 0 || pick == 2) begin
                rdy = 1'b0;
            end
            if (pick == 1 || pick == 2) begin
                ioBufferFull = 1'b1;
            end
            if (pick < 3) begin
                stallBudget--;
                stallCount++;
            end
        end
    endtask

    // cycles counted from the edge after the request goes up
    task automatic awaitDone(input bit forData, output int latency);
        int cycles;
        bit frozen;
        stallBudget = MaxStall;
        cycles      = 0;
        applyStall();
        forever begin
            @(negedge clk);
            frozen = !rdy || ioBufferFull;
            if (frozen && (fetchOut.done || dataOut.done)) begin
                failRun("done pulse raised while the transfer was frozen");
            end
            if (forData && fetchOut.done) begin
                failRun("fetch done pulse raised while waiting for the data response");
            end
            if (!forData && dataOut.done) begin
                failRun("data done pulse raised while waiting for the fetch response");
            end
            if (forData ? dataOut.done : fetchOut.done) begin
                break;
            end
            cycles++;
            if (cycles > WaitLimit) begin
                failRun("no done pulse arrived within the wait limit");
            end
            @(posedge clk);
            #1;
            applyStall();
        end
        latency = cycles;
    endtask

    task automatic releaseRequests(input bit dropData, input bit dropFetch);
        @(posedge clk);
        #1;
        if (dropData) begin
            dataIn.valid = 1'b0;
        end
        if (dropFetch) begin
            fetchIn.valid = 1'b0;
        end
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
    endtask

    task automatic storeData(input memCtrlPkg::accessLen_e count, input logic [31:0] addr,
                             input logic [31:0] wdata, input int expLatency);
        int latency;
        dataIn = '{valid: 1'b1, isStore: 1'b1, len: count, addr: addr, wdata: wdata};
        awaitDone(1'b1, latency);
        checkLatency("store", latency, expLatency);
        modelWrite(addr, count, wdata);
        releaseRequests(1'b1, 1'b0);
    endtask

    task automatic loadData(input memCtrlPkg::accessLen_e count, input logic [31:0] addr,
                            input int expLatency);
        int                   latency;
        memBusPkg::dataResp_s exp;
        dataIn = '{valid: 1'b1, isStore: 1'b0, len: count, addr: addr, wdata: 32'h0};
        awaitDone(1'b1, latency);
        checkLatency("load", latency, expLatency);
        exp = '{done: 1'b1, rdata: modelRead(addr, int'(count))};
        checkData(dataOut, exp, "load");
        releaseRequests(1'b1, 1'b0);
    endtask

    task automatic fetchInst(input logic [31:0] addr, input int expLatency);
        int                    latency;
        memBusPkg::fetchResp_s exp;
        fetchIn = '{valid: 1'b1, addr: addr};
        awaitDone(1'b0, latency);
        checkLatency("fetch", latency, expLatency);
        exp = '{done: 1'b1, inst: modelRead(addr, 4)};
        checkFetch(fetchOut, exp, "fetch");
        releaseRequests(1'b0, 1'b1);
    endtask

    task automatic applyReset();
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic wordRoundTrip();
        logic [31:0] addr;
        addr = $urandom;
        storeData(memCtrlPkg::lenWord, addr, $urandom, 4);
        loadData(memCtrlPkg::lenWord, addr, 5);
        fetchInst(addr, 5);
    endtask

    task automatic partialStores();
        logic [31:0] base;
        base = $urandom & ~32'h3;
        storeData(memCtrlPkg::lenWord, base, $urandom, 4);
        storeData(memCtrlPkg::lenByte, base + 32'd1, $urandom, 1);
        storeData(memCtrlPkg::lenHalf, base + 32'd2, $urandom, 2);
        loadData(memCtrlPkg::lenWord, base, 5);
        storeData(memCtrlPkg::lenByte, base, $urandom, 1);
        // halfword across the middle of the word
        storeData(memCtrlPkg::lenHalf, base + 32'd1, $urandom, 2);
        loadData(memCtrlPkg::lenWord, base, 5);
    endtask

    task automatic narrowLoads();
        logic [31:0] base;
        base = $urandom & ~32'h3;
        // top bits set so missing zero-extension shows up
        storeData(memCtrlPkg::lenWord, base, $urandom | 32'h8080_8080, 4);
        for (int i = 0; i < 4; i++) begin
            loadData(memCtrlPkg::lenByte, base + 32'(i), 2);
        end
        loadData(memCtrlPkg::lenHalf, base, 3);
        loadData(memCtrlPkg::lenHalf, base + 32'd2, 3);
    endtask

    task automatic simultaneousRequests();
        logic [31:0]           fetchAddr;
        logic [31:0]           dataAddr;
        int                    latency;
        memBusPkg::dataResp_s  expData;
        memBusPkg::fetchResp_s expFetch;
        fetchAddr = $urandom;
        dataAddr  = $urandom;
        storeData(memCtrlPkg::lenWord, fetchAddr, $urandom, 4);
        storeData(memCtrlPkg::lenWord, dataAddr, $urandom, 4);
        fetchIn = '{valid: 1'b1, addr: fetchAddr};
        dataIn  = '{valid: 1'b1, isStore: 1'b0, len: memCtrlPkg::lenWord,
                    addr: dataAddr, wdata: 32'h0};
        awaitDone(1'b1, latency);
        checkLatency("load beside fetch", latency, 5);
        expData = '{done: 1'b1, rdata: modelRead(dataAddr, 4)};
        checkData(dataOut, expData, "load beside fetch");
        // fetch stays raised and is taken once the sequencer is idle
        releaseRequests(1'b1, 1'b0);
        awaitDone(1'b0, latency);
        checkLatency("fetch after load", latency, 5);
        expFetch = '{done: 1'b1, inst: modelRead(fetchAddr, 4)};
        checkFetch(fetchOut, expFetch, "fetch after load");
        releaseRequests(1'b0, 1'b1);
    endtask

    task automatic stalledTraffic();
        logic [31:0] addr;
        stallOn    = 1'b1;
        stallCount = 0;
        repeat (StallRounds) begin
            addr = $urandom;
            storeData(memCtrlPkg::lenWord, addr, $urandom, -1);
            storeData(pickLen(), addr, $urandom, -1);
            loadData(pickLen(), addr, -1);
            fetchInst(addr, -1);
        end
        stallOn = 1'b0;
        if (stallCount == 0) begin
            failRun("no stall cycle was applied during the stalled transfers");
        end
    endtask

    task automatic idleAfterReset();
        memBusPkg::fetchResp_s quietFetch;
        memBusPkg::dataResp_s  quietData;
        quietFetch = '0;
        quietData  = '0;
        applyReset();
        repeat (IdleCycles) begin
            @(negedge clk);
            checkFetch(fetchOut, quietFetch, "idle after reset");
            checkData(dataOut, quietData, "idle after reset");
        end
    endtask

    initial begin
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        fetchIn      = '0;
        dataIn       = '0;
        stallOn      = 1'b0;
        stallBudget  = 0;
        stallCount   = 0;
        void'($urandom(Seed));

        applyReset();
        wordRoundTrip();
        partialStores();
        narrowLoads();
        simultaneousRequests();
        stalledTraffic();
        idleAfterReset();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== src/memSubsystem.sv ====
`timescale 1ns/1ps

module memSubsystem #(
    parameter int RamAddrWidth = 12
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_rdy,
    input  logic                  i_ioBufferFull,
    input  memBusPkg::fetchReq_s  i_fetch,
    input  memBusPkg::dataReq_s   i_data,
    output memBusPkg::fetchResp_s o_fetch,
    output memBusPkg::dataResp_s  o_data
);

    memBusPkg::ramPort_s    ramPort;
    logic [7:0]             ramData;
    memCtrlPkg::access_e    state;
    memCtrlPkg::stage_t     stage;
    memCtrlPkg::accessLen_e len;
    logic                   capture;
    logic                   fetchDone;
    logic                   dataDone;
    logic [31:0]            inst;
    logic [31:0]            loadData;

    memSequencer i_memSequencer (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_fetch        (i_fetch),
        .i_data         (i_data),
        .o_ram          (ramPort),
        .o_state        (state),
        .o_stage        (stage),
        .o_len          (len),
        .o_capture      (capture),
        .o_fetchDone    (fetchDone),
        .o_dataDone     (dataDone)
    );

    wordAssembler i_wordAssembler (
        .clk        (clk),
        .rst        (rst),
        .i_ramData  (ramData),
        .i_capture  (capture),
        .i_state    (state),
        .i_stage    (stage),
        .i_len      (len),
        .o_inst     (inst),
        .o_loadData (loadData)
    );

    byteRam #(
        .RamAddrWidth (RamAddrWidth)
    ) i_byteRam (
        .clk     (clk),
        .i_port  (ramPort),
        .o_rdata (ramData)
    );

    assign o_fetch.done  = fetchDone;
    assign o_fetch.inst  = inst;
    assign o_data.done   = dataDone;
    assign o_data.rdata  = loadData;

endmodule

// ==== src/byteRam.sv ====
`timescale 1ns/1ps

module byteRam #(
    parameter int RamAddrWidth = 12
) (
    input  logic                clk,
    input  memBusPkg::ramPort_s i_port,
    output logic [7:0]          o_rdata
);

    localparam int Depth = 2 ** RamAddrWidth;

    logic [7:0]              mem [Depth];
    logic [RamAddrWidth-1:0] index;

    // upper address bits are dropped, so addresses wrap
    assign index = i_port.addr[RamAddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (i_port.we) begin
            mem[index] <= i_port.wdata;
        end
        // read returns the old byte on a same-cycle write
        o_rdata <= mem[index];
    end

    knownWriteAddr: assert property (
        @(posedge clk)
        i_port.we |-> !$isunknown(i_port.addr)
    );

endmodule

// ==== src/wordAssembler.sv ====
`timescale 1ns/1ps

module wordAssembler (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [7:0]             i_ramData,
    input  logic                   i_capture,
    input  memCtrlPkg::access_e    i_state,
    input  memCtrlPkg::stage_t     i_stage,
    input  memCtrlPkg::accessLen_e i_len,
    output logic [31:0]            o_inst,
    output logic [31:0]            o_loadData
);

    memBusPkg::wordLanes_u held;
    memBusPkg::wordLanes_u merged;
    logic [1:0]            lane;
    logic [2:0]            lenCount;

    // byte returned at stage s belongs in lane s-1, stage 4 wraps to lane 3
    assign lane     = i_stage[1:0] - 2'd1;
    assign lenCount = i_len;

    // cleared while idle so each transfer starts from zero
    always_ff @(posedge clk) begin
        if (rst || i_state == memCtrlPkg::idle) begin
            held.word <= '0;
        end else if (i_capture) begin
            held.lanes[lane] <= i_ramData;
        end
    end

    // the last byte goes straight through with the stored lanes
    always_comb begin
        merged = held;
        if (i_state != memCtrlPkg::idle && i_stage != '0) begin
            merged.lanes[lane] = i_ramData;
        end
        // zero-extend above the requested length
        for (int i = 0; i < 4; i++) begin
            if (i >= lenCount) begin
                merged.lanes[i] = '0;
            end
        end
    end

    assign o_inst     = (i_state == memCtrlPkg::readInst) ? merged.word : '0;
    assign o_loadData = (i_state == memCtrlPkg::readData) ? merged.word : '0;

endmodule

// ==== src/memSequencer.sv ====
`timescale 1ns/1ps

module memSequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_rdy,
    input  logic                   i_ioBufferFull,
    input  memBusPkg::fetchReq_s   i_fetch,
    input  memBusPkg::dataReq_s    i_data,
    output memBusPkg::ramPort_s    o_ram,
    output memCtrlPkg::access_e    o_state,
    output memCtrlPkg::stage_t     o_stage,
    output memCtrlPkg::accessLen_e o_len,
    output logic                   o_capture,
    output logic                   o_fetchDone,
    output logic                   o_dataDone
);

    memCtrlPkg::access_e    state;
    memCtrlPkg::stage_t     stage;
    memCtrlPkg::accessLen_e len;
    logic [31:0]            baseAddr;
    memBusPkg::wordLanes_u  storeWord;

    logic                   enable;
    logic                   reading;
    logic                   lastStage;
    logic [2:0]             lenCount;
    memCtrlPkg::stage_t     addrStage;

    // global ready and a full I/O buffer both freeze the transfer
    assign enable   = i_rdy && !i_ioBufferFull;
    assign reading  = (state == memCtrlPkg::readInst) || (state == memCtrlPkg::readData);
    assign lenCount = len;

    // reads finish one stage later than writes because of the RAM latency
    always_comb begin
        lastStage = 1'b0;
        case (state)
            memCtrlPkg::readInst,
            memCtrlPkg::readData: begin
                lastStage = (stage == lenCount);
            end
            memCtrlPkg::writeData: begin
                lastStage = (stage == lenCount - 3'd1);
            end
            default: begin
                lastStage = 1'b0;
            end
        endcase
    end

    // when frozen, re-present the previous byte address so the
    // registered RAM output still lines up with the stage after the stall
    always_comb begin
        addrStage = stage;
        if (!enable && reading && stage != '0) begin
            addrStage = stage - 3'd1;
        end
    end

    assign o_ram.addr  = baseAddr + 32'(addrStage);
    assign o_ram.wdata = storeWord.lanes[stage[1:0]];
    assign o_ram.we    = enable && (state == memCtrlPkg::writeData);

    // a byte returns one stage after its address
    assign o_capture   = enable && reading && (stage != '0);

    assign o_fetchDone = enable && (state == memCtrlPkg::readInst) && lastStage;
    assign o_dataDone  = enable && lastStage &&
                         ((state == memCtrlPkg::readData) || (state == memCtrlPkg::writeData));

    assign o_state = state;
    assign o_stage = stage;
    assign o_len   = len;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memCtrlPkg::idle;
            stage <= '0;
            len   <= memCtrlPkg::lenWord;
        end else if (enable) begin
            case (state)
                memCtrlPkg::idle: begin
                    stage <= '0;
                    // data path wins over fetch
                    if (i_data.valid) begin
                        state <= i_data.isStore ? memCtrlPkg::writeData : memCtrlPkg::readData;
                        len   <= i_data.len;
                    end else if (i_fetch.valid) begin
                        state <= memCtrlPkg::readInst;
                        len   <= memCtrlPkg::lenWord;
                    end
                end
                default: begin
                    if (lastStage) begin
                        state <= memCtrlPkg::idle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
            endcase
        end
    end

    // request payload, taken on the accepting edge
    always_ff @(posedge clk) begin
        if (enable && state == memCtrlPkg::idle) begin
            baseAddr       <= i_data.valid ? i_data.addr : i_fetch.addr;
            storeWord.word <= i_data.wdata;
        end
    end

    doneExclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(o_fetchDone && o_dataDone)
    );

    writeOnlyInStore: assert property (
        @(posedge clk) disable iff (rst)
        o_ram.we |-> (state == memCtrlPkg::writeData)
    );

    stageWithinLen: assert property (
        @(posedge clk) disable iff (rst)
        (state != memCtrlPkg::idle) |-> (stage <= lenCount)
    );

endmodule

// ==== src/memBusPkg.sv ====
package memBusPkg;

    // one word seen whole or by byte lane, lane 0 is the low byte
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lanes;
    } wordLanes_u;

    // instruction fetch client
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } fetchReq_s;

    typedef struct packed {
        logic        done;
        logic [31:0] inst;
    } fetchResp_s;

    // load/store client
    typedef struct packed {
        logic                   valid;
        logic                   isStore;
        memCtrlPkg::accessLen_e len;
        logic [31:0]            addr;
        logic [31:0]            wdata;
    } dataReq_s;

    typedef struct packed {
        logic        done;
        logic [31:0] rdata;
    } dataResp_s;

    // byte-wide RAM port
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [7:0]  wdata;
    } ramPort_s;

endpackage

// ==== src/memCtrlPkg.sv ====
package memCtrlPkg;

    // width of the byte stage counter, counts 0 to 4
    localparam int StageWidth = 3;

    // sequencer states
    typedef enum logic [1:0] {
        idle      = 2'd0,
        readInst  = 2'd1,
        readData  = 2'd2,
        writeData = 2'd3
    } access_e;

    // access length as a plain byte count
    typedef enum logic [2:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } accessLen_e;

    typedef logic [StageWidth-1:0] stage_t;

endpackage
